/* rtl/mem_bus_pkg.sv */
package mem_bus_pkg;

    // One cache line is 64 bytes
    parameter int line_bits = 512;

    // Byte address to line index shift
    parameter int line_shift = 6;

    // Opcodes seen by the memory controller
    typedef enum logic [1:0] {
        OP_IDLE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b11
    } mem_op_t;

endpackage

/* rtl/fpu_req_pkg.sv */
package fpu_req_pkg;

    // Transfer length in cache lines
    parameter int len_bits = 8;

    // DMA controller sequencing states
    typedef enum logic [1:0] {
        IDLE,
        ACTIVE,
        DONE
    } dma_state_t;

endpackage

/* rtl/fpu_req_latch.sv */
`timescale 1ns/1ps

module fpu_req_latch #(
    parameter int addr_width = 32
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             request,
    input  logic                             rd_wr,
    input  logic [addr_width-1:0]            address,
    input  logic [fpu_req_pkg::len_bits-1:0] request_size,
    input  logic                             request_done,
    output logic                             req_valid,
    output logic                             req_write,
    output logic [addr_width-1:0]            req_address,
    output logic [fpu_req_pkg::len_bits-1:0] req_size
);

    logic accept;

    // One descriptor at a time and never a zero-length one
    assign accept = request && !req_valid && (request_size != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else if (req_valid && request_done) begin
            req_valid <= 1'b0;
        end else if (accept) begin
            req_valid <= 1'b1;
        end
    end

    // Descriptor fields held so the FPU may reuse its bus
    always_ff @(posedge clk) begin
        if (accept) begin
            req_write   <= rd_wr;
            req_address <= address;
            req_size    <= request_size;
        end
    end

endmodule

/* rtl/fpu_dma_ctrl.sv */
`timescale 1ns/1ps

module fpu_dma_ctrl #(
    parameter int addr_width = 32
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // Descriptor from the latch
    input  logic                              req_valid,
    input  logic                              req_write,
    input  logic [addr_width-1:0]             req_address,
    input  logic [fpu_req_pkg::len_bits-1:0]  req_size,
    // FPU side
    input  logic                              fpu_ready,
    input  logic [mem_bus_pkg::line_bits-1:0] write_data,
    // From the memory controller
    input  logic                              tx_done,
    input  logic                              rd_valid,
    input  logic [mem_bus_pkg::line_bits-1:0] read_line,
    // To the memory controller
    output mem_bus_pkg::mem_op_t              op,
    output logic [addr_width-1:0]             raw_address,
    output logic [mem_bus_pkg::line_bits-1:0] write_line,
    // Back to the FPU
    output logic [mem_bus_pkg::line_bits-1:0] read_data,
    output logic                              dram_ready,
    output logic                              request_done
);

    import mem_bus_pkg::*;
    import fpu_req_pkg::*;

    dma_state_t          state;
    dma_state_t          state_next;
    logic [len_bits-1:0] line_cnt;
    logic                lines_left;

    // Stop issuing once every line has completed
    assign lines_left = (line_cnt != req_size);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Completed lines of the current transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_cnt <= '0;
        end else if (state != ACTIVE) begin
            line_cnt <= '0;
        end else if (tx_done) begin
            line_cnt <= line_cnt + len_bits'(1);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_next = ACTIVE;
                end
            end
            ACTIVE: begin
                if (!lines_left) begin
                    state_next = DONE;
                end
            end
            // Single-cycle completion pulse
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_comb begin
        op          = OP_IDLE;
        raw_address = '0;
        write_line  = '0;
        read_data   = '0;
        dram_ready  = 1'b0;
        if (state == ACTIVE) begin
            // Hold off the memory while the FPU buffer is not ready
            if (fpu_ready && lines_left) begin
                op = req_write ? OP_WRITE : OP_READ;
            end
            raw_address = req_address + (addr_width'(line_cnt) << line_shift);
            if (req_write) begin
                write_line = write_data;
                dram_ready = 1'b1;
            end else begin
                read_data  = read_line;
                dram_ready = rd_valid;
            end
        end
    end

    assign request_done = (state == DONE);

endmodule

/* rtl/line_mem_ctrl.sv */
`timescale 1ns/1ps

module line_mem_ctrl #(
    parameter int addr_width  = 32,
    parameter int mem_latency = 3,
    parameter int mem_lines   = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  mem_bus_pkg::mem_op_t              op,
    input  logic [addr_width-1:0]             raw_address,
    input  logic [mem_bus_pkg::line_bits-1:0] write_line,
    output logic                              tx_done,
    output logic                              rd_valid,
    output logic [mem_bus_pkg::line_bits-1:0] read_line
);

    import mem_bus_pkg::*;

    localparam int idx_bits = (mem_lines > 1) ? $clog2(mem_lines) : 1;
    localparam int cnt_bits = (mem_latency > 0) ? $clog2(mem_latency + 1) : 1;

    logic [line_bits-1:0] mem_array [mem_lines];

    logic                 busy;
    logic [cnt_bits-1:0]  lat_cnt;
    logic                 write_q;
    logic [idx_bits-1:0]  idx_q;
    logic [line_bits-1:0] line_q;
    logic                 accept;
    logic                 finish;

    // Take a new opcode only between operations
    assign accept = !busy && (op != OP_IDLE);
    assign finish = busy && (lat_cnt == cnt_bits'(mem_latency));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            lat_cnt <= '0;
        end else if (finish) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else if (busy) begin
            lat_cnt <= lat_cnt + cnt_bits'(1);
        end
    end

    // Operation captured at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            write_q <= (op == OP_WRITE);
            idx_q   <= idx_bits'((raw_address >> line_shift) % mem_lines);
            line_q  <= write_line;
        end
    end

    // Write lands in the array on the completion cycle
    always_ff @(posedge clk) begin
        if (finish && write_q) begin
            mem_array[idx_q] <= line_q;
        end
    end

    assign tx_done   = finish;
    assign rd_valid  = finish && !write_q;
    assign read_line = rd_valid ? mem_array[idx_q] : '0;

endmodule

/* rtl/fpu_dma_top.sv */
`timescale 1ns/1ps

module fpu_dma_top #(
    parameter int addr_width  = 32,
    parameter int mem_latency = 3,
    parameter int mem_lines   = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              request,
    input  logic                              rd_wr,
    input  logic                              fpu_ready,
    input  logic [addr_width-1:0]             address,
    input  logic [fpu_req_pkg::len_bits-1:0]  request_size,
    input  logic [mem_bus_pkg::line_bits-1:0] write_data,
    output logic [mem_bus_pkg::line_bits-1:0] read_data,
    output logic                              dram_ready,
    output logic                              request_done
);

    import mem_bus_pkg::*;
    import fpu_req_pkg::*;

    // Held descriptor
    logic                  req_valid;
    logic                  req_write;
    logic [addr_width-1:0] req_address;
    logic [len_bits-1:0]   req_size;

    // Memory controller link
    mem_op_t               op;
    logic [addr_width-1:0] raw_address;
    logic [line_bits-1:0]  write_line;
    logic [line_bits-1:0]  read_line;
    logic                  tx_done;
    logic                  rd_valid;

    fpu_req_latch #(
        .addr_width(addr_width)
    ) u_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .request     (request),
        .rd_wr       (rd_wr),
        .address     (address),
        .request_size(request_size),
        .request_done(request_done),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_address (req_address),
        .req_size    (req_size)
    );

    fpu_dma_ctrl #(
        .addr_width(addr_width)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_address (req_address),
        .req_size    (req_size),
        .fpu_ready   (fpu_ready),
        .write_data  (write_data),
        .tx_done     (tx_done),
        .rd_valid    (rd_valid),
        .read_line   (read_line),
        .op          (op),
        .raw_address (raw_address),
        .write_line  (write_line),
        .read_data   (read_data),
        .dram_ready  (dram_ready),
        .request_done(request_done)
    );

    line_mem_ctrl #(
        .addr_width (addr_width),
        .mem_latency(mem_latency),
        .mem_lines  (mem_lines)
    ) u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .raw_address(raw_address),
        .write_line (write_line),
        .tx_done    (tx_done),
        .rd_valid   (rd_valid),
        .read_line  (read_line)
    );

endmodule

/* testbench/fpu_dma_tb.sv */
`timescale 1ns/1ps

module fpu_dma_tb;

    import mem_bus_pkg::*;
    import fpu_req_pkg::*;

    localparam int addr_width  = 32;
    localparam int mem_latency = 3;
    localparam int mem_lines   = 16;

    logic                  clk;
    logic                  rst_n;
    logic                  request;
    logic                  rd_wr;
    logic                  fpu_ready;
    logic [addr_width-1:0] address;
    logic [len_bits-1:0]   request_size;
    logic [line_bits-1:0]  write_data;
    logic [line_bits-1:0]  read_data;
    logic                  dram_ready;
    logic                  request_done;

    // Transfers from the golden file
    logic                  row_write [$];
    logic [addr_width-1:0] row_addr [$];
    int unsigned           row_len [$];
    logic [31:0]           row_tag [$];
    logic                  row_done [$];

    // Current transfer bookkeeping
    logic        cur_write;
    logic [31:0] cur_tag;
    int unsigned wr_idx;
    int unsigned beats;
    int unsigned dones;
    int unsigned stall_left;

    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 0;

    fpu_dma_top #(
        .addr_width (addr_width),
        .mem_latency(mem_latency),
        .mem_lines  (mem_lines)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .request     (request),
        .rd_wr       (rd_wr),
        .fpu_ready   (fpu_ready),
        .address     (address),
        .request_size(request_size),
        .write_data  (write_data),
        .read_data   (read_data),
        .dram_ready  (dram_ready),
        .request_done(request_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s (controller state %0d)", why, u_dut.u_ctrl.state);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("Timeout, run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic check_value(input string name, input logic [line_bits-1:0] got,
                               input logic [line_bits-1:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    // Line k of a transfer is sixteen copies of tag + k
    function automatic logic [line_bits-1:0] line_pattern(input logic [31:0] tag,
                                                          input int unsigned k);
        logic [31:0] word;
        word = tag + k;
        return {16{word}};
    endfunction

    // Next inputs with optional random stretches of fpu_ready low
    task automatic drive_cycle(input logic stall);
        @(posedge clk);
        #2;
        request    = 1'b0;
        write_data = line_pattern(cur_tag, wr_idx);
        if (!stall) begin
            fpu_ready = 1'b1;
        end else if (stall_left != 0) begin
            fpu_ready = 1'b0;
            stall_left--;
        end else if ($urandom % 4 == 0) begin
            fpu_ready  = 1'b0;
            stall_left = 1 + $urandom % 4;
        end else begin
            fpu_ready = 1'b1;
        end
    endtask

    // Mid-cycle look at the outputs
    task automatic sample_cycle();
        @(negedge clk);
        if (request_done) begin
            dones++;
        end
        if (cur_write && u_dut.tx_done) begin
            // Writes keep dram_ready high for the whole transfer
            check_value("dram_ready", dram_ready, 1'b1);
            wr_idx++;
        end
        if (!cur_write && dram_ready) begin
            check_value("read_data", read_data, line_pattern(cur_tag, beats));
            beats++;
        end
    endtask

    task automatic run_transfer(input int row, input logic stall);
        int unsigned tail;
        cur_write = row_write[row];
        cur_tag   = row_tag[row];
        wr_idx    = 0;
        beats     = 0;
        dones     = 0;
        tail      = 0;
        @(posedge clk);
        #2;
        request      = 1'b1;
        rd_wr        = cur_write;
        address      = row_addr[row];
        request_size = len_bits'(row_len[row]);
        write_data   = line_pattern(cur_tag, 0);
        fpu_ready    = 1'b1;
        if (row_done[row]) begin
            // A few idle cycles after completion catch a second pulse
            while (dones == 0 || tail < 4) begin
                sample_cycle();
                if (dones != 0) begin
                    tail++;
                end
                drive_cycle(stall);
            end
            check_value("request_done pulses", dones, 1);
            if (cur_write) begin
                check_value("tx_done count", wr_idx, row_len[row]);
            end else begin
                check_value("dram_ready beats", beats, row_len[row]);
            end
        end else begin
            repeat (20) begin
                sample_cycle();
                drive_cycle(stall);
            end
            check_value("request_done pulses", dones, 0);
        end
    endtask

    initial begin
        int fd;
        int n;
        string text;
        logic [31:0] f_dir;
        logic [31:0] f_addr;
        logic [31:0] f_len;
        logic [31:0] f_tag;
        logic [31:0] f_done;
        int unsigned total_len;
        int unsigned seed_val;
        seed_val     = $urandom(35);
        rst_n        = 1'b0;
        request      = 1'b0;
        rd_wr        = 1'b0;
        fpu_ready    = 1'b0;
        address      = '0;
        request_size = '0;
        write_data   = '0;
        stall_left   = 0;
        cur_write    = 1'b0;
        cur_tag      = '0;
        wr_idx       = 0;
        beats        = 0;
        dones        = 0;
        total_len    = 0;
        fd = $fopen("testbench/dma_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the golden file testbench/dma_golden.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (text.len() > 0 && text.getc(0) != "/") begin
                n = $sscanf(text, "%h %h %h %h %h", f_dir, f_addr, f_len, f_tag, f_done);
                if (n == 5) begin
                    row_write.push_back(f_dir[0]);
                    row_addr.push_back(f_addr);
                    row_len.push_back(f_len);
                    row_tag.push_back(f_tag);
                    row_done.push_back(f_done[0]);
                    total_len += f_len;
                end
            end
        end
        $fclose(fd);
        if (row_write.size() == 0) begin
            abort_run("The golden file holds no transfers");
        end
        cycle_limit = total_len * (mem_latency + 1) * 4 + 200;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Outputs stay quiet until the first request
        repeat (3) begin
            @(negedge clk);
            check_value("dram_ready", dram_ready, 1'b0);
            check_value("request_done", request_done, 1'b0);
        end

        // First write and read run with fpu_ready held high
        for (int i = 0; i < row_write.size(); i++) begin
            run_transfer(i, i >= 2);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* fpu_dma_top.f */
rtl/mem_bus_pkg.sv
rtl/fpu_req_pkg.sv
rtl/fpu_req_latch.sv
rtl/fpu_dma_ctrl.sv
rtl/line_mem_ctrl.sv
rtl/fpu_dma_top.sv
testbench/fpu_dma_tb.sv

/* Bender.yml */
package:
  name: fpu_dma

sources:
  - rtl/mem_bus_pkg.sv
  - rtl/fpu_req_pkg.sv
  - rtl/fpu_req_latch.sv
  - rtl/fpu_dma_ctrl.sv
  - rtl/line_mem_ctrl.sv
  - rtl/fpu_dma_top.sv
  - target: test
    files:
      - testbench/fpu_dma_tb.sv

/* testbench/dma_golden.txt */
// Columns, all hex: dir (1 write, 0 read), base byte address, length in lines,
// data tag of the write that filled the lines, expect request_done (1 or 0)
1 00000000 4 a5a50000 1
0 00000000 4 a5a50000 1
1 00000200 4 3c3c1000 1
0 00000000 4 a5a50000 1
0 00000200 4 3c3c1000 1
1 00000400 0 deadbeef 0
1 00000100 2 77770000 1
0 00000100 2 77770000 1
0 00000000 4 a5a50000 1
0 00000200 4 3c3c1000 1
